//--- hw/disp_pkg.sv
// shared raster timing, picture and memory sizes and enums, imported by every display module
`default_nettype none

package disp_pkg;

	// --------------------
	// raster timing
	// --------------------
	// horizontal, in pixel clocks
	localparam int H_ACTIVE = 32;
	localparam int H_FRONT  = 4;
	localparam int H_SYNC   = 8;
	localparam int H_BACK   = 16;
	// vertical, in lines
	localparam int V_ACTIVE = 24;
	localparam int V_FRONT  = 2;
	localparam int V_SYNC   = 2;
	localparam int V_BACK   = 4;
	localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int COORD_W  = 7;

	// --------------------
	// picture and memory
	// --------------------
	// 16x16 macroblocks, at most 2x1 of them
	localparam int MB_SIZE_LOG2 = 4;
	localparam int MB_W         = 2;
	// four samples per word, first pixel in the top byte
	localparam int WORD_W     = 32;
	localparam int ADDR_W     = 9;
	localparam int MEM_WORDS  = 512;
	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
	localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

	typedef logic [7:0]        pix_t;
	typedef logic [WORD_W-1:0] word_t;
	typedef logic [ADDR_W-1:0] addr_t;

	// frame RAM ports, in priority order
	typedef enum logic [2:0] {PORT_Y, PORT_U, PORT_V, PORT_WR, PORT_NONE} port_t;

	// horizontal phase of the scan
	typedef enum logic [1:0] {ACTIVE, FRONT, SYNC, BACK} scan_state_t;

endpackage

`default_nettype wire

//--- hw/vga_timing.sv
// raster generator: h/v counters, syncs, active video, pixel position and line-start strobe
`default_nettype none

module vga_timing import disp_pkg::*; (
	input  wire                vga_clk,
	input  wire                rst_n,
	output logic               hsync_o,
	output logic               vsync_o,
	output logic               active_o,
	output logic               line_start_o,
	output logic [COORD_W-1:0] x_o,
	output logic [COORD_W-1:0] y_o
);

	scan_state_t h_state;
	logic [COORD_W-1:0] h_cnt;
	logic [COORD_W-1:0] v_cnt;
	logic h_last;
	logic v_in_sync;

	// a row runs back porch, active, front porch, sync
	always_comb
	begin
		case (h_state)
			ACTIVE: h_last = (h_cnt == COORD_W'(H_ACTIVE - 1));
			FRONT:  h_last = (h_cnt == COORD_W'(H_FRONT - 1));
			SYNC:   h_last = (h_cnt == COORD_W'(H_SYNC - 1));
			default: h_last = (h_cnt == COORD_W'(H_BACK - 1));
		endcase
		v_in_sync = (v_cnt >= COORD_W'(V_ACTIVE + V_FRONT)) &&
			(v_cnt < COORD_W'(V_ACTIVE + V_FRONT + V_SYNC));
	end

	// phase and row counters
	always_ff @(posedge vga_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			h_state <= BACK;
			h_cnt   <= '0;
			// start in vertical blank so row 0 gets its line start
			v_cnt   <= COORD_W'(V_ACTIVE);
		end
		else if (h_last)
		begin
			h_cnt <= '0;
			case (h_state)
				BACK:   h_state <= ACTIVE;
				ACTIVE: h_state <= FRONT;
				FRONT:  h_state <= SYNC;
				default:
				begin
					h_state <= BACK;
					// new row begins where hsync ends
					v_cnt <= (v_cnt == COORD_W'(V_TOTAL - 1)) ? '0 : v_cnt + 1'b1;
				end
			endcase
		end
		else
			h_cnt <= h_cnt + 1'b1;
	end

	// registered outputs, one cycle behind the counters
	always_ff @(posedge vga_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			hsync_o      <= 1'b1;
			vsync_o      <= 1'b1;
			active_o     <= 1'b0;
			line_start_o <= 1'b0;
			x_o          <= '0;
			y_o          <= '0;
		end
		else
		begin
			hsync_o  <= (h_state != SYNC);
			vsync_o  <= !v_in_sync;
			active_o <= (h_state == ACTIVE) && (v_cnt < COORD_W'(V_ACTIVE));
			// first back porch cycle = hsync rising edge
			line_start_o <= (h_state == BACK) && (h_cnt == '0) && (v_cnt < COORD_W'(V_ACTIVE));
			x_o <= (h_state == ACTIVE) ? h_cnt : '0;
			y_o <= v_cnt;
		end
	end

endmodule

`default_nettype wire

//--- hw/line_addr_gen.sv
// per-line word addresses of the Y, U and V rows in the double-buffered frame store
`default_nettype none

module line_addr_gen import disp_pkg::*; (
	input  wire                vga_clk,
	input  wire                rst_n,
	input  wire                frame_start_i,
	input  wire [MB_W-1:0]     pic_width_mbs_i,
	input  wire [MB_W-1:0]     pic_height_mbs_i,
	input  wire [9:0]          pic_num_i,
	input  wire                line_start_i,
	input  wire [COORD_W-1:0]  y_i,
	output logic [COORD_W-1:0] width_o,
	output logic [COORD_W-1:0] height_o,
	output addr_t              y_addr_o,
	output addr_t              u_addr_o,
	output addr_t              v_addr_o
);

	// settings waiting for the next line start
	logic [MB_W-1:0] pend_w_mbs;
	logic [MB_W-1:0] pend_h_mbs;
	logic pend_odd;

	addr_t area_mbs;
	addr_t luma_words;
	addr_t buf_base;
	addr_t luma_row;
	addr_t chroma_row;
	addr_t u_start;

	// layout, all in words
	always_comb
	begin
		area_mbs   = ADDR_W'(pend_w_mbs) * ADDR_W'(pend_h_mbs);
		// w*h/4 = mbs * 256 / 4
		luma_words = area_mbs << (2 * MB_SIZE_LOG2 - 2);
		// odd picture in buffer 0, even one at 3wh/8
		buf_base   = pend_odd ? '0 : luma_words + (luma_words >> 1);
		luma_row   = ADDR_W'(pend_w_mbs) << (MB_SIZE_LOG2 - 2);
		chroma_row = luma_row >> 1;
		u_start    = buf_base + luma_words;
	end

	always_ff @(posedge vga_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pend_w_mbs <= '0;
			pend_h_mbs <= '0;
			pend_odd   <= 1'b0;
			width_o    <= '0;
			height_o   <= '0;
			y_addr_o   <= '0;
			u_addr_o   <= '0;
			v_addr_o   <= '0;
		end
		else
		begin
			if (frame_start_i)
			begin
				pend_w_mbs <= pic_width_mbs_i;
				pend_h_mbs <= pic_height_mbs_i;
				pend_odd   <= pic_num_i[0];
			end
			if (line_start_i)
			begin
				width_o  <= COORD_W'(pend_w_mbs) << MB_SIZE_LOG2;
				height_o <= COORD_W'(pend_h_mbs) << MB_SIZE_LOG2;
				y_addr_o <= buf_base + ADDR_W'(y_i) * luma_row;
				// chroma rows are shared by two luma rows
				u_addr_o <= u_start + ADDR_W'(y_i >> 1) * chroma_row;
				v_addr_o <= u_start + (luma_words >> 2) + ADDR_W'(y_i >> 1) * chroma_row;
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/plane_fetch.sv
// prefetch FIFO for one picture plane, reloaded with a new row address at each line start
`default_nettype none

module plane_fetch import disp_pkg::*; (
	input  wire         vga_clk,
	input  wire         rst_n,
	input  wire         load_i,
	input  wire addr_t  base_i,
	input  wire         pop_i,
	output logic        req_o,
	output addr_t       req_addr_o,
	input  wire         rd_valid_i,
	input  wire word_t  rd_data_i,
	output word_t       head_o
);

	word_t fifo_mem [FIFO_DEPTH];
	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic [FIFO_CNT_W-1:0] count;
	// next row word not yet returned
	addr_t next_addr;
	// row address is valid one cycle after line start
	logic load_q;
	// idle until the first row address arrives
	logic armed;

	// read latency is one cycle, so rd_valid_i marks the single read in flight
	assign req_o      = armed && !load_q &&
		((count + FIFO_CNT_W'(rd_valid_i)) < FIFO_CNT_W'(FIFO_DEPTH));
	assign req_addr_o = next_addr + ADDR_W'(rd_valid_i);
	assign head_o     = fifo_mem[rd_ptr];

	// --------------------
	// pointers and fill level
	// --------------------
	always_ff @(posedge vga_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			load_q    <= 1'b0;
			armed     <= 1'b0;
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			next_addr <= '0;
		end
		else
		begin
			load_q <= load_i;
			if (load_q)
			begin
				// flush, a word returning now belongs to the old row
				armed     <= 1'b1;
				wr_ptr    <= '0;
				rd_ptr    <= '0;
				count     <= '0;
				next_addr <= base_i;
			end
			else
			begin
				if (rd_valid_i)
				begin
					wr_ptr    <= wr_ptr + 1'b1;
					next_addr <= next_addr + 1'b1;
				end
				if (pop_i)
					rd_ptr <= rd_ptr + 1'b1;
				count <= count + FIFO_CNT_W'(rd_valid_i) - FIFO_CNT_W'(pop_i);
			end
		end
	end

	// word storage
	always_ff @(posedge vga_clk)
	begin
		if (rd_valid_i && !load_q)
			fifo_mem[wr_ptr] <= rd_data_i;
	end

	// the pixel pipe must never outrun the prefetch
	a_no_pop_empty: assert property (@(posedge vga_clk) disable iff (!rst_n)
		pop_i |-> (count != '0))
		else $error("plane fetch popped while empty");

endmodule

`default_nettype wire

//--- hw/frame_buffer_arb.sv
// on-chip frame RAM shared by the three plane fetchers and the decoder write port
`default_nettype none

module frame_buffer_arb import disp_pkg::*; (
	input  wire         vga_clk,
	input  wire         rst_n,
	input  wire         req_y_i,
	input  wire         req_u_i,
	input  wire         req_v_i,
	input  wire addr_t  addr_y_i,
	input  wire addr_t  addr_u_i,
	input  wire addr_t  addr_v_i,
	input  wire         wr_en_i,
	input  wire addr_t  wr_addr_i,
	input  wire word_t  wr_data_i,
	output logic        wr_full_o,
	output word_t       rd_data_o,
	output logic        valid_y_o,
	output logic        valid_u_o,
	output logic        valid_v_o
);

	word_t mem [MEM_WORDS];
	port_t gnt;
	port_t gnt_q;
	addr_t rd_addr;

	// fixed priority Y, U, V, then writes
	always_comb
	begin
		wr_full_o = req_y_i | req_u_i | req_v_i;
		if (req_y_i)
			gnt = PORT_Y;
		else if (req_u_i)
			gnt = PORT_U;
		else if (req_v_i)
			gnt = PORT_V;
		else if (wr_en_i)
			gnt = PORT_WR;
		else
			gnt = PORT_NONE;
		case (gnt)
			PORT_U:  rd_addr = addr_u_i;
			PORT_V:  rd_addr = addr_v_i;
			default: rd_addr = addr_y_i;
		endcase
	end

	// single-port RAM, read data one cycle after grant
	always_ff @(posedge vga_clk)
	begin
		if (gnt == PORT_WR)
			mem[wr_addr_i] <= wr_data_i;
		if (gnt == PORT_Y || gnt == PORT_U || gnt == PORT_V)
			rd_data_o <= mem[rd_addr];
	end

	// grant kept to route the returning word
	always_ff @(posedge vga_clk or negedge rst_n)
	begin
		if (!rst_n)
			gnt_q <= PORT_NONE;
		else
			gnt_q <= gnt;
	end

	assign valid_y_o = (gnt_q == PORT_Y);
	assign valid_u_o = (gnt_q == PORT_U);
	assign valid_v_o = (gnt_q == PORT_V);

	// a write accepted at the port owns the RAM, no read shares its cycle
	a_one_grant: assert property (@(posedge vga_clk) disable iff (!rst_n)
		(wr_en_i && !wr_full_o) |-> (gnt == PORT_WR))
		else $error("write accepted while a read held the frame RAM");

	// returned words only go to fetchers that asked
	a_no_idle_grant: assert property (@(posedge vga_clk) disable iff (!rst_n)
		({valid_y_o, valid_u_o, valid_v_o} & ~$past({req_y_i, req_u_i, req_v_i})) == 3'b000)
		else $error("read data returned to an idle fetcher");

endmodule

`default_nettype wire

//--- hw/pixel_pipe.sv
// pixel pipeline: FIFO pops, byte select, YUV to RGB, blanking and sync delay, 3 cycles deep
`default_nettype none

module pixel_pipe import disp_pkg::*; (
	input  wire                vga_clk,
	input  wire                rst_n,
	input  wire [COORD_W-1:0]  x_i,
	input  wire [COORD_W-1:0]  y_i,
	input  wire                active_i,
	input  wire                hsync_i,
	input  wire                vsync_i,
	input  wire [COORD_W-1:0]  width_i,
	input  wire [COORD_W-1:0]  height_i,
	input  wire word_t         y_word_i,
	input  wire word_t         u_word_i,
	input  wire word_t         v_word_i,
	output logic               pop_y_o,
	output logic               pop_u_o,
	output logic               pop_v_o,
	output pix_t               vga_r_o,
	output pix_t               vga_g_o,
	output pix_t               vga_b_o,
	output logic               vga_hsync_o,
	output logic               vga_vsync_o,
	output logic               vga_de_o
);

	logic in_pic;
	// word in use, the popped head or the held copy
	word_t y_cur, u_cur, v_cur;
	word_t y_hold, u_hold, v_hold;
	pix_t s1_y, s1_u, s1_v;
	logic s1_vis;
	logic signed [8:0] d, e;
	pix_t s2_y;
	logic signed [17:0] s2_r_off, s2_g_off, s2_b_off;
	logic s2_vis;
	logic signed [10:0] r_sum, g_sum, b_sum;
	logic [2:0] hs_d, vs_d, de_d;

	function automatic pix_t clip(input logic signed [10:0] val);
		if (val < 0)
			return 8'd0;
		else if (val > 255)
			return 8'd255;
		else
			return pix_t'(val);
	endfunction

	// --------------------
	// select stage
	// --------------------
	always_comb
	begin
		in_pic  = active_i && (x_i < width_i) && (y_i < height_i);
		// one luma word per 4 pixels, one chroma word per 8
		pop_y_o = in_pic && (x_i[1:0] == 2'd0);
		pop_u_o = in_pic && (x_i[2:0] == 3'd0);
		pop_v_o = pop_u_o;
		y_cur   = pop_y_o ? y_word_i : y_hold;
		u_cur   = pop_u_o ? u_word_i : u_hold;
		v_cur   = pop_v_o ? v_word_i : v_hold;
		// centred chroma offsets
		d = $signed({1'b0, s1_u}) - 9'sd128;
		e = $signed({1'b0, s1_v}) - 9'sd128;
		// final adds, shift is arithmetic
		r_sum = $signed({3'b000, s2_y}) + 11'(s2_r_off >>> 8);
		g_sum = $signed({3'b000, s2_y}) - 11'(s2_g_off >>> 8);
		b_sum = $signed({3'b000, s2_y}) + 11'(s2_b_off >>> 8);
	end

	// sample data path, pixel 0 in the top byte
	always_ff @(posedge vga_clk)
	begin
		if (pop_y_o)
			y_hold <= y_word_i;
		if (pop_u_o)
			u_hold <= u_word_i;
		if (pop_v_o)
			v_hold <= v_word_i;
		s1_y <= y_cur[{~x_i[1:0], 3'b000} +: 8];
		s1_u <= u_cur[{~x_i[2:1], 3'b000} +: 8];
		s1_v <= v_cur[{~x_i[2:1], 3'b000} +: 8];
		// multiply stage
		s2_y     <= s1_y;
		s2_r_off <= 18'(e * 359);
		s2_g_off <= 18'(d * 88 + e * 183);
		s2_b_off <= 18'(d * 454);
	end

	// --------------------
	// control and output register
	// --------------------
	always_ff @(posedge vga_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			s1_vis      <= 1'b0;
			s2_vis      <= 1'b0;
			hs_d        <= '1;
			vs_d        <= '1;
			de_d        <= '0;
			vga_r_o     <= '0;
			vga_g_o     <= '0;
			vga_b_o     <= '0;
		end
		else
		begin
			s1_vis <= in_pic;
			s2_vis <= s1_vis;
			hs_d   <= {hs_d[1:0], hsync_i};
			vs_d   <= {vs_d[1:0], vsync_i};
			de_d   <= {de_d[1:0], active_i};
			// black outside the decoded picture
			vga_r_o <= s2_vis ? clip(r_sum) : 8'd0;
			vga_g_o <= s2_vis ? clip(g_sum) : 8'd0;
			vga_b_o <= s2_vis ? clip(b_sum) : 8'd0;
		end
	end

	assign vga_hsync_o = hs_d[2];
	assign vga_vsync_o = vs_d[2];
	assign vga_de_o    = de_d[2];

endmodule

`default_nettype wire

//--- hw/video_display_top.sv
// display top level: raster, line addressing, plane fetchers, frame RAM and pixel pipe
`default_nettype none

module video_display_top import disp_pkg::*; (
	input  wire              vga_clk,
	input  wire              rst_n,
	input  wire              frame_start_i,
	input  wire [MB_W-1:0]   pic_width_mbs_i,
	input  wire [MB_W-1:0]   pic_height_mbs_i,
	input  wire [9:0]        pic_num_i,
	input  wire              wr_en_i,
	input  wire addr_t       wr_addr_i,
	input  wire word_t       wr_data_i,
	output logic             wr_full_o,
	output logic             vga_hsync_o,
	output logic             vga_vsync_o,
	output logic             vga_de_o,
	output pix_t             vga_r_o,
	output pix_t             vga_g_o,
	output pix_t             vga_b_o
);

	// raster
	logic [COORD_W-1:0] x, y, width, height;
	logic hsync, vsync, active, line_start;
	// row addresses and fetch traffic
	addr_t y_addr, u_addr, v_addr;
	addr_t addr_y, addr_u, addr_v;
	logic req_y, req_u, req_v;
	logic valid_y, valid_u, valid_v;
	word_t rd_data;
	// FIFO heads and pops
	word_t head_y, head_u, head_v;
	logic pop_y, pop_u, pop_v;

	vga_timing i_vga_timing (
		.vga_clk(vga_clk), .rst_n(rst_n),
		.hsync_o(hsync), .vsync_o(vsync), .active_o(active),
		.line_start_o(line_start), .x_o(x), .y_o(y)
	);

	line_addr_gen i_line_addr_gen (
		.vga_clk(vga_clk), .rst_n(rst_n),
		.frame_start_i(frame_start_i), .pic_width_mbs_i(pic_width_mbs_i),
		.pic_height_mbs_i(pic_height_mbs_i), .pic_num_i(pic_num_i),
		.line_start_i(line_start), .y_i(y),
		.width_o(width), .height_o(height),
		.y_addr_o(y_addr), .u_addr_o(u_addr), .v_addr_o(v_addr)
	);

	plane_fetch fetch_y (
		.vga_clk(vga_clk), .rst_n(rst_n), .load_i(line_start), .base_i(y_addr),
		.pop_i(pop_y), .req_o(req_y), .req_addr_o(addr_y),
		.rd_valid_i(valid_y), .rd_data_i(rd_data), .head_o(head_y)
	);

	plane_fetch fetch_u (
		.vga_clk(vga_clk), .rst_n(rst_n), .load_i(line_start), .base_i(u_addr),
		.pop_i(pop_u), .req_o(req_u), .req_addr_o(addr_u),
		.rd_valid_i(valid_u), .rd_data_i(rd_data), .head_o(head_u)
	);

	plane_fetch fetch_v (
		.vga_clk(vga_clk), .rst_n(rst_n), .load_i(line_start), .base_i(v_addr),
		.pop_i(pop_v), .req_o(req_v), .req_addr_o(addr_v),
		.rd_valid_i(valid_v), .rd_data_i(rd_data), .head_o(head_v)
	);

	frame_buffer_arb i_frame_buffer_arb (
		.vga_clk(vga_clk), .rst_n(rst_n),
		.req_y_i(req_y), .req_u_i(req_u), .req_v_i(req_v),
		.addr_y_i(addr_y), .addr_u_i(addr_u), .addr_v_i(addr_v),
		.wr_en_i(wr_en_i), .wr_addr_i(wr_addr_i), .wr_data_i(wr_data_i),
		.wr_full_o(wr_full_o), .rd_data_o(rd_data),
		.valid_y_o(valid_y), .valid_u_o(valid_u), .valid_v_o(valid_v)
	);

	pixel_pipe i_pixel_pipe (
		.vga_clk(vga_clk), .rst_n(rst_n),
		.x_i(x), .y_i(y), .active_i(active), .hsync_i(hsync), .vsync_i(vsync),
		.width_i(width), .height_i(height),
		.y_word_i(head_y), .u_word_i(head_u), .v_word_i(head_v),
		.pop_y_o(pop_y), .pop_u_o(pop_u), .pop_v_o(pop_v),
		.vga_r_o(vga_r_o), .vga_g_o(vga_g_o), .vga_b_o(vga_b_o),
		.vga_hsync_o(vga_hsync_o), .vga_vsync_o(vga_vsync_o), .vga_de_o(vga_de_o)
	);

endmodule

`default_nettype wire

//--- testbench/tb_checks.svh
// compare tasks and failure helper, included inside the body of the display testbench module
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

	// --------------------
	// failure exit
	// --------------------
	task automatic stop_with_failure();
		$display("Done: errors found");
		$fatal(1, "display testbench stopped at the first error");
	endtask

	// one colour channel against its expected value
	task automatic check_pix(input string what, input pix_t got, input pix_t exp);
		if (got !== exp)
		begin
			$display("Error: %0d ns %s got %0d, expected %0d", $time, what, got, exp);
			stop_with_failure();
		end
	endtask

	// single-bit strobe or level against its expected value
	task automatic check_level(input string what, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("Error: %0d ns %s got %b, expected %b", $time, what, got, exp);
			stop_with_failure();
		end
	endtask

	// lengths of sync pulses, active runs and frames, in cycles or lines
	task automatic check_timing(input string what, input int got, input int exp);
		if (got != exp)
		begin
			$display("Error: %0d ns %s was %0d long, expected %0d", $time, what, got, exp);
			stop_with_failure();
		end
	endtask

	// x, y and frame packed into one lookup key
	function automatic int pix_key(input int frame, input int x, input int y);
		return (frame << 16) | (y << 8) | x;
	endfunction

`endif

//--- testbench/tb_video_display.sv
// testbench for the display top level, replays testbench/display_testdata.txt and checks the raster
`default_nettype none

module tb_video_display import disp_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 100;
	localparam int LINE_CYC   = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int FRAME_CYC  = LINE_CYC * V_TOTAL;

	logic vga_clk;
	logic rst_n;
	logic frame_start_i;
	logic [MB_W-1:0] pic_width_mbs_i;
	logic [MB_W-1:0] pic_height_mbs_i;
	logic [9:0] pic_num_i;
	logic wr_en_i;
	addr_t wr_addr_i;
	word_t wr_data_i;
	logic wr_full_o;
	logic vga_hsync_o;
	logic vga_vsync_o;
	logic vga_de_o;
	pix_t vga_r_o;
	pix_t vga_g_o;
	pix_t vga_b_o;

	// commands in file order, S and W records
	byte cmd_tag[$];
	int cmd_a[$];
	int cmd_b[$];
	int cmd_c[$];
	int cmd_d[$];
	// expected pixels by frame, x and y
	pix_t exp_r[int];
	pix_t exp_g[int];
	pix_t exp_b[int];
	int n_writes = 0;
	int max_frame = 0;
	logic parsed = 1'b0;
	// cycles a pending write spent waiting on wr_full_o
	int wr_stalls = 0;

	// monitor state
	int frame_cnt = 0;
	int row = 0;
	int col = 0;
	int hs_len = 0;
	int vs_len = 0;
	int matched = 0;
	logic prev_hs = 1'b1;
	logic prev_vs = 1'b1;
	logic prev_de = 1'b0;
	logic seen_sync = 1'b0;

	`include "tb_checks.svh"

	video_display_top i_video_display_top (
		.vga_clk(vga_clk), .rst_n(rst_n), .frame_start_i(frame_start_i),
		.pic_width_mbs_i(pic_width_mbs_i), .pic_height_mbs_i(pic_height_mbs_i),
		.pic_num_i(pic_num_i), .wr_en_i(wr_en_i), .wr_addr_i(wr_addr_i),
		.wr_data_i(wr_data_i), .wr_full_o(wr_full_o),
		.vga_hsync_o(vga_hsync_o), .vga_vsync_o(vga_vsync_o), .vga_de_o(vga_de_o),
		.vga_r_o(vga_r_o), .vga_g_o(vga_g_o), .vga_b_o(vga_b_o)
	);

	initial
		vga_clk = 1'b0;
	always
		#(CLK_PERIOD / 2) vga_clk = ~vga_clk;

	// --------------------
	// data file
	// --------------------
	task automatic read_testdata();
		int fd;
		string line;
		int a, b, c, d, e, f;
		fd = $fopen("testbench/display_testdata.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the test data file");
			stop_with_failure();
		end
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() < 2 || line[0] == "#")
					continue;
				if (line[0] == "E")
				begin
					void'($sscanf(line, "E %d %d %d %d %d %d", a, b, c, d, e, f));
					exp_r[pix_key(a, b, c)] = pix_t'(d);
					exp_g[pix_key(a, b, c)] = pix_t'(e);
					exp_b[pix_key(a, b, c)] = pix_t'(f);
					if (a > max_frame)
						max_frame = a;
				end
				else if (line[0] == "W")
				begin
					void'($sscanf(line, "W %h %h %h", a, b, c));
					cmd_tag.push_back("W");
					cmd_a.push_back(a);
					cmd_b.push_back(b);
					cmd_c.push_back(c);
					cmd_d.push_back(0);
					n_writes += b;
				end
				else if (line[0] == "S")
				begin
					void'($sscanf(line, "S %d %d %d %d", a, b, c, d));
					cmd_tag.push_back("S");
					cmd_a.push_back(a);
					cmd_b.push_back(b);
					cmd_c.push_back(c);
					cmd_d.push_back(d);
				end
			end
			$fclose(fd);
		end
	endtask

	// one word through the write port, held while the arbiter is busy
	task automatic write_word(input addr_t addr, input word_t data);
		@(posedge vga_clk);
		wr_en_i   <= 1'b1;
		wr_addr_i <= addr;
		wr_data_i <= data;
		@(negedge vga_clk);
		while (wr_full_o)
		begin
			wr_stalls++;
			@(negedge vga_clk);
		end
		@(posedge vga_clk);
		wr_en_i <= 1'b0;
		// idle gap
		repeat ($urandom % 4)
			@(posedge vga_clk);
	endtask

	// settings pulse in the vertical blank before the given frame
	task automatic apply_settings(input int frame, input int w_mbs, input int h_mbs, input int num);
		if (frame_cnt >= frame)
		begin
			$display("picture settings for frame %0d arrived too late", frame);
			stop_with_failure();
		end
		else
		begin
			wait (frame_cnt == frame);
			@(posedge vga_clk);
			frame_start_i    <= 1'b1;
			pic_width_mbs_i  <= MB_W'(w_mbs);
			pic_height_mbs_i <= MB_W'(h_mbs);
			pic_num_i        <= 10'(num);
			@(posedge vga_clk);
			frame_start_i <= 1'b0;
		end
	endtask

	// --------------------
	// stimulus
	// --------------------
	initial
	begin
		void'($urandom(32'hbeb5));
		rst_n            = 1'b0;
		frame_start_i    = 1'b0;
		pic_width_mbs_i  = '0;
		pic_height_mbs_i = '0;
		pic_num_i        = '0;
		wr_en_i          = 1'b0;
		wr_addr_i        = '0;
		wr_data_i        = '0;
		read_testdata();
		parsed = 1'b1;
		repeat (10)
			@(posedge vga_clk);
		rst_n <= 1'b1;
		foreach (cmd_tag[i])
		begin
			if (cmd_tag[i] == "W")
			begin
				for (int k = 0; k < cmd_b[i]; k++)
					write_word(addr_t'(cmd_a[i] + k), word_t'(cmd_c[i]));
			end
			else
				apply_settings(cmd_a[i], cmd_b[i], cmd_c[i], cmd_d[i]);
		end
		// last expected frame fully scanned
		wait (frame_cnt > max_frame);
		if (matched != exp_r.num())
		begin
			$display("only %0d of %0d expected pixels were displayed", matched, exp_r.num());
			stop_with_failure();
		end
		else if (wr_stalls == 0)
		begin
			$display("no write ever waited on wr_full_o");
			stop_with_failure();
		end
		else
		begin
			$display("Done: no errors");
			$finish;
		end
	end

	// --------------------
	// raster monitor
	// --------------------
	always @(negedge vga_clk)
	begin
		if (rst_n)
		begin
			if (!vga_hsync_o || !vga_vsync_o)
				seen_sync = 1'b1;
			// quiet outputs until the first sync pulse
			if (!seen_sync)
				check_level("de before first sync", vga_de_o, 1'b0);
			if (!vga_de_o)
			begin
				check_pix("red in blanking", vga_r_o, 8'd0);
				check_pix("green in blanking", vga_g_o, 8'd0);
				check_pix("blue in blanking", vga_b_o, 8'd0);
			end
			// fetchers sit full through vertical blank so the write port is free
			if (!vga_vsync_o)
				check_level("wr_full_o in vertical sync", wr_full_o, 1'b0);
			// hsync width
			if (!vga_hsync_o)
				hs_len++;
			else if (!prev_hs)
			begin
				check_timing("hsync pulse", hs_len, H_SYNC);
				hs_len = 0;
			end
			// vsync width and active lines per frame
			if (!vga_vsync_o)
				vs_len++;
			else if (!prev_vs)
			begin
				check_timing("vsync pulse", vs_len, V_SYNC * LINE_CYC);
				vs_len = 0;
			end
			if (prev_vs && !vga_vsync_o)
			begin
				if (frame_cnt > 0)
					check_timing("active lines in frame", row, V_ACTIVE);
				frame_cnt++;
				row = 0;
			end
			// pixel position and expected colour
			if (vga_de_o)
			begin
				if (exp_r.exists(pix_key(frame_cnt, col, row)))
				begin
					check_pix("red", vga_r_o, exp_r[pix_key(frame_cnt, col, row)]);
					check_pix("green", vga_g_o, exp_g[pix_key(frame_cnt, col, row)]);
					check_pix("blue", vga_b_o, exp_b[pix_key(frame_cnt, col, row)]);
					matched++;
				end
				col++;
			end
			else if (prev_de)
			begin
				check_timing("active pixels in line", col, H_ACTIVE);
				col = 0;
				row++;
			end
			prev_hs = vga_hsync_o;
			prev_vs = vga_vsync_o;
			prev_de = vga_de_o;
		end
	end

	// watchdog, scaled by the amount of work in the data file
	initial
	begin
		longint limit;
		wait (parsed);
		limit = (longint'(n_writes) + longint'(max_frame + 3) * FRAME_CYC) * 2;
		#(limit * CLK_PERIOD);
		$display("simulation timed out before all frames were checked");
		stop_with_failure();
	end

endmodule

`default_nettype wire

//--- testbench/display_testdata.txt
# S frame width_mbs height_mbs pic_num (decimal) | W addr count data (hex), count words of data
# E frame x y r g b (decimal), expected pixel, frame 1 is the first after reset
W 000 40 4080c0f0
W 040 40 08080808
W 080 20 90809080
W 0a0 20 70707070
S 2 2 1 1
S 3 1 1 3
W 0c0 80 20202020
W 140 20 80808080
W 160 20 c0c0c0c0
S 4 2 1 2
E 1 0 0 0 0 0
E 2 0 0 41 70 92
E 2 3 2 217 252 240
E 2 6 7 169 204 192
E 2 13 5 105 134 156
E 2 20 10 0 14 36
E 2 31 15 0 20 8
E 2 5 16 0 0 0
E 2 31 23 0 0 0
E 3 3 0 71 255 27
E 3 0 9 0 192 0
E 3 6 15 23 255 0
E 3 16 0 0 0 0
E 3 8 16 0 0 0
E 4 0 0 121 0 32
E 4 31 15 121 0 32
E 4 17 8 121 0 32
E 4 10 20 0 0 0

//--- flist.f
+incdir+testbench
hw/disp_pkg.sv
hw/vga_timing.sv
hw/line_addr_gen.sv
hw/plane_fetch.sv
hw/frame_buffer_arb.sv
hw/pixel_pipe.sv
hw/video_display_top.sv
testbench/tb_video_display.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_video_display
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f flist.f
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
